// ==== files.f ====
+incdir+src
src/pspin_pkg.sv
src/her_queue.sv
src/task_scheduler.sv
src/feedback_arbiter.sv
src/pspin_dispatch.sv
tb/tb_pspin_dispatch.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_pspin_dispatch
FILELIST  := files.f
FLAGS     := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing -Wall
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module pspin_dispatch -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== tb/dispatch_stim.txt ====
// Columns: HER word _ inject flag _ cluster_active mask _ expected pspin_active
// _ NIC stall cycles _ cluster hold-off cycles
10000001_1_0_0_0_0
10000002_1_f_1_0_0
10000003_1_7_0_0_0
10000004_1_f_1_0_0
10000005_1_8_0_0_8
10000006_1_f_1_0_8
10000007_1_f_1_0_0
00000000_0_f_1_0_0
20000001_1_f_1_f_0
20000002_1_e_0_f_0
20000003_1_f_1_f_0
20000004_1_d_0_f_0
20000005_1_f_1_f_0
20000006_1_b_0_f_0
20000007_1_f_1_f_0
20000008_1_3_0_f_0
20000009_1_f_1_f_0
2000000a_1_f_1_f_0
2000000b_1_5_0_f_0
2000000c_1_f_1_f_0
2000000d_1_f_1_f_0
00000000_0_0_0_0_0
30000001_1_f_1_0_4
30000002_1_9_0_3_0
30000003_1_f_1_0_0
30000004_1_6_0_0_0

// ==== tb/tb_pspin_dispatch.sv ====
/*
 * Testbench for the dispatch top level
 * Cluster and NIC models, compare tasks, stimulus file reader and cycle limit
 */
`timescale 1ns/1ps
`include "pspin_settings.svh"

module tb_pspin_dispatch;

  import pspin_pkg::*;

  localparam int n_cl      = `PSPIN_NUM_CLUSTERS;
  localparam int slots     = `PSPIN_HERS_PER_CLUSTER;
  localparam int q_depth   = `PSPIN_HER_QUEUE_DEPTH;
  localparam int max_steps = 64;

  logic clk_i = 1'b0;
  logic rst_ni = 1'b0;
  logic her_valid_i;
  her_descr_t her_i;
  logic her_ready_o;
  cluster_mask_t cluster_task_valid_o;
  her_descr_t cluster_task_o;
  cluster_mask_t cluster_task_ready_i;
  cluster_mask_t cluster_fb_valid_i;
  feedback_descr_t [n_cl-1:0] cluster_fb_i;
  cluster_mask_t cluster_fb_ready_o;
  logic nic_feedback_valid_o;
  feedback_descr_t nic_feedback_o;
  logic nic_feedback_ready_i;
  cluster_mask_t cluster_active_i;
  logic pspin_active_o;

  logic [51:0] stim_mem [max_steps];
  int n_steps;
  int limit = 0;
  int cyc = 0;
  int errors = 0;
  int hold_until = 0;
  int stall_until = 0;
  logic [31:0] lfsr = 32'hf0df;

  // Model state of the clusters and the expected HER order
  her_descr_t exp_q [$];
  her_descr_t slot_word [n_cl][slots];
  int head [n_cl];
  int cnt [n_cl];
  int fb_delay [n_cl];
  cluster_mask_t fb_on;
  cluster_idx_t exp_cl;
  int last_cl = n_cl - 1;
  logic offer_open = 1'b0;
  feedback_descr_t exp_fb;
  feedback_descr_t stall_word;
  logic stalled = 1'b0;
  int accepted_hers = 0;
  int issued = 0;
  int returned = 0;

  pspin_dispatch uut (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .her_valid_i          (her_valid_i),
    .her_i                (her_i),
    .her_ready_o          (her_ready_o),
    .cluster_task_valid_o (cluster_task_valid_o),
    .cluster_task_o       (cluster_task_o),
    .cluster_task_ready_i (cluster_task_ready_i),
    .cluster_fb_valid_i   (cluster_fb_valid_i),
    .cluster_fb_i         (cluster_fb_i),
    .cluster_fb_ready_o   (cluster_fb_ready_o),
    .nic_feedback_valid_o (nic_feedback_valid_o),
    .nic_feedback_o       (nic_feedback_o),
    .nic_feedback_ready_i (nic_feedback_ready_i),
    .cluster_active_i     (cluster_active_i),
    .pspin_active_o       (pspin_active_o)
  );

  always #5 clk_i = ~clk_i;

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic take_bit();
    lfsr = lfsr_next(lfsr);
    return lfsr[0];
  endfunction

  // Round-robin target is the first cluster with a free slot after the last recipient
  function automatic cluster_idx_t next_target();
    int c;
    for (int i = 0; i < n_cl; i++) begin
      c = (last_cl + 1 + i) % n_cl;
      if (cnt[c] < slots) return cluster_idx_t'(c);
    end
    return cluster_idx_t'((last_cl + 1) % n_cl);
  endfunction

  function automatic logic in_flight();
    logic busy;
    busy = 1'b0;
    for (int k = 0; k < n_cl; k++) begin
      if (cnt[k] != 0) busy = 1'b1;
    end
    return busy;
  endfunction

  task automatic check_task(input cluster_idx_t cl, input her_descr_t word);
    if (exp_q.size() == 0) begin
      errors++;
      $display("A task was issued to cluster %0d while no HER was pending", cl);
    end else if (word !== exp_q[0]) begin
      errors++;
      $display("[ERROR] %0t: task word %h, expected %h", $time, word, exp_q[0]);
    end
    if (cl !== exp_cl) begin
      errors++;
      $display("[ERROR] %0t: task went to cluster %0d, expected %0d", $time, cl, exp_cl);
    end
  endtask

  task automatic check_feedback(input feedback_descr_t word);
    if (word !== exp_fb) begin
      errors++;
      $display("[ERROR] %0t: NIC feedback %h, expected %h", $time, word, exp_fb);
    end
  endtask

  task automatic check_active(input logic exp);
    if (pspin_active_o !== exp) begin
      errors++;
      $display("[ERROR] %0t: pspin_active_o is %b, expected %b", $time, pspin_active_o, exp);
    end
  endtask

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    if (limit != 0 && cyc >= limit) begin
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // Cluster and NIC models sample the DUT before the edge takes effect
  always @(posedge clk_i) begin : models
    logic fb_taken;
    feedback_descr_t fb_word;
    cluster_mask_t rdy;
    int tail;
    if (rst_ni) begin
      fb_taken = 1'b0;
      fb_word  = '0;
      if (her_ready_o !== (exp_q.size() < q_depth)) begin
        errors++;
        $display("[ERROR] %0t: her_ready_o is %b with %0d HERs queued",
                 $time, her_ready_o, exp_q.size());
      end

      if (cluster_task_valid_o != '0) begin
        if (!$onehot(cluster_task_valid_o)) begin
          errors++;
          $display("[ERROR] %0t: several clusters offered a task at once", $time);
        end
        if (!offer_open) begin
          exp_cl     = next_target();
          offer_open = 1'b1;
        end
        for (int k = 0; k < n_cl; k++) begin
          if (cluster_task_valid_o[k] && cluster_task_ready_i[k]) begin
            check_task(cluster_idx_t'(k), cluster_task_o);
            if (cnt[k] >= slots) begin
              errors++;
              $display("Cluster %0d received a task with all its slots busy", k);
            end else begin
              tail = (head[k] + cnt[k]) % slots;
              slot_word[k][tail] = cluster_task_o;
              cnt[k]++;
            end
            if (exp_q.size() != 0) void'(exp_q.pop_front());
            last_cl    = k;
            offer_open = 1'b0;
            issued++;
          end
        end
      end

      for (int k = 0; k < n_cl; k++) begin
        if (fb_on[k] && cluster_fb_ready_o[k]) begin
          fb_word     = ~slot_word[k][head[k]];
          head[k]     = (head[k] + 1) % slots;
          cnt[k]--;
          fb_on[k]    = 1'b0;
          fb_delay[k] = {take_bit(), take_bit()};
          fb_taken    = 1'b1;
        end
      end

      if (stalled) begin
        if (!nic_feedback_valid_o) begin
          errors++;
          $display("NIC feedback was withdrawn during a stall at %0t", $time);
        end else begin
          exp_fb = stall_word;
          check_feedback(nic_feedback_o);
        end
      end
      if (nic_feedback_valid_o && nic_feedback_ready_i) begin
        if (!fb_taken) begin
          errors++;
          $display("The NIC accepted feedback that no cluster returned at %0t", $time);
        end else begin
          exp_fb = fb_word;
          check_feedback(nic_feedback_o);
          returned++;
        end
      end else if (fb_taken) begin
        errors++;
        $display("Cluster feedback was taken without reaching the NIC at %0t", $time);
      end
      stalled    = nic_feedback_valid_o && !nic_feedback_ready_i;
      stall_word = nic_feedback_o;

      if (her_valid_i && her_ready_o) begin
        exp_q.push_back(her_i);
        accepted_hers++;
      end

      // Next cycle's cluster and NIC drive
      for (int k = 0; k < n_cl; k++) begin
        if (!fb_on[k] && cnt[k] != 0) begin
          if (fb_delay[k] == 0) begin
            fb_on[k] = 1'b1;
            cluster_fb_i[k] <= ~slot_word[k][head[k]];
          end else begin
            fb_delay[k]--;
          end
        end
        rdy[k] = (cyc >= hold_until) && (cnt[k] < slots) && take_bit();
      end
      cluster_fb_valid_i   <= fb_on;
      cluster_task_ready_i <= rdy;
      nic_feedback_ready_i <= (cyc >= stall_until);
    end
  end

  initial begin : main
    logic [51:0] line;
    logic prev_active;
    her_valid_i          = 1'b0;
    her_i                = '0;
    cluster_task_ready_i = '0;
    cluster_fb_valid_i   = '0;
    cluster_fb_i         = '0;
    nic_feedback_ready_i = 1'b0;
    cluster_active_i     = '0;
    fb_on                = '0;
    prev_active          = 1'b0;
    for (int k = 0; k < n_cl; k++) begin
      head[k]     = 0;
      cnt[k]      = 0;
      fb_delay[k] = 0;
    end

    $readmemh("tb/dispatch_stim.txt", stim_mem);
    n_steps = 0;
    while (n_steps < max_steps && !$isunknown(stim_mem[n_steps])) n_steps++;
    limit = 50 * n_steps + 200;
    if (n_steps == 0) begin
      errors++;
      $display("The stimulus file is missing or holds no lines");
    end

    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    if (her_ready_o !== 1'b1 || cluster_task_valid_o !== '0 || nic_feedback_valid_o !== 1'b0) begin
      errors++;
      $display("[ERROR] %0t: idle state after reset is wrong", $time);
    end
    check_active(1'b0);

    for (int step = 0; step < n_steps; step++) begin
      line = stim_mem[step];
      her_valid_i      <= line[16];
      her_i            <= line[51:20];
      cluster_active_i <= line[15:12];
      if (line[7:4] != 0) stall_until <= cyc + int'(line[7:4]);
      if (line[3:0] != 0) hold_until <= cyc + int'(line[3:0]);
      @(posedge clk_i);
      // Status still reflects the mask of the previous step
      check_active(prev_active);
      while (line[16] && !(her_valid_i && her_ready_o)) begin
        @(posedge clk_i);
      end
      her_valid_i <= 1'b0;
      @(posedge clk_i);
      check_active(line[8]);
      prev_active = line[8];
    end

    // Let every task come back through the NIC
    while (exp_q.size() != 0 || in_flight()) @(posedge clk_i);
    repeat (2) @(posedge clk_i);
    if (issued != accepted_hers || returned != issued) begin
      errors++;
      $display("Lost work: %0d HERs accepted, %0d tasks issued, %0d feedback words returned",
               accepted_hers, issued, returned);
    end

    $display("Errors: %0d, HERs: %0d, tasks: %0d, feedback words: %0d",
             errors, accepted_hers, issued, returned);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== src/pspin_dispatch.sv ====
/*
 * Handler dispatch top level: HER queue, task scheduler, feedback merge
 * and the all-clusters-active status
 */
`timescale 1ns/1ps
`include "pspin_settings.svh"

module pspin_dispatch (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,

  // From the packet generator
  input  logic                                                her_valid_i,
  input  pspin_pkg::her_descr_t                               her_i,
  output logic                                                her_ready_o,

  // Tasks to the clusters
  output pspin_pkg::cluster_mask_t                            cluster_task_valid_o,
  output pspin_pkg::her_descr_t                               cluster_task_o,
  input  pspin_pkg::cluster_mask_t                            cluster_task_ready_i,

  // Completion feedback from the clusters
  input  pspin_pkg::cluster_mask_t                            cluster_fb_valid_i,
  input  pspin_pkg::feedback_descr_t [`PSPIN_NUM_CLUSTERS-1:0] cluster_fb_i,
  output pspin_pkg::cluster_mask_t                            cluster_fb_ready_o,

  // Feedback to the packet generator
  output logic                                                nic_feedback_valid_o,
  output pspin_pkg::feedback_descr_t                          nic_feedback_o,
  input  logic                                                nic_feedback_ready_i,

  input  pspin_pkg::cluster_mask_t                            cluster_active_i,
  output logic                                                pspin_active_o
);

  import pspin_pkg::*;

  // Queue head toward the scheduler
  logic          task_valid;
  her_descr_t    task_descr;
  logic          task_ready;

  // Slot credit return
  logic          fb_done;
  cluster_idx_t  fb_cluster;

  cluster_mask_t cluster_active_q;

  her_queue i_her_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .her_valid_i  (her_valid_i),
    .her_i        (her_i),
    .her_ready_o  (her_ready_o),
    .task_valid_o (task_valid),
    .task_o       (task_descr),
    .task_ready_i (task_ready)
  );

  task_scheduler i_task_scheduler (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .task_valid_i         (task_valid),
    .task_i               (task_descr),
    .task_ready_o         (task_ready),
    .cluster_task_valid_o (cluster_task_valid_o),
    .cluster_task_o       (cluster_task_o),
    .cluster_task_ready_i (cluster_task_ready_i),
    .fb_done_i            (fb_done),
    .fb_cluster_i         (fb_cluster)
  );

  feedback_arbiter i_feedback_arbiter (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .cluster_fb_valid_i   (cluster_fb_valid_i),
    .cluster_fb_i         (cluster_fb_i),
    .cluster_fb_ready_o   (cluster_fb_ready_o),
    .nic_feedback_valid_o (nic_feedback_valid_o),
    .nic_feedback_o       (nic_feedback_o),
    .nic_feedback_ready_i (nic_feedback_ready_i),
    .fb_done_o            (fb_done),
    .fb_cluster_o         (fb_cluster)
  );

  // High only when every cluster was active last cycle
  assign pspin_active_o = &cluster_active_q;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      cluster_active_q <= '0;
    end else begin
      cluster_active_q <= cluster_active_i;
    end
  end

endmodule

// ==== src/feedback_arbiter.sv ====
/*
 * Round-robin merge of cluster completion feedback toward the NIC
 * Also reports which cluster freed a handler slot
 */
`timescale 1ns/1ps
`include "pspin_settings.svh"

module feedback_arbiter (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,

  input  pspin_pkg::cluster_mask_t                            cluster_fb_valid_i,
  input  pspin_pkg::feedback_descr_t [`PSPIN_NUM_CLUSTERS-1:0] cluster_fb_i,
  output pspin_pkg::cluster_mask_t                            cluster_fb_ready_o,

  output logic                                                nic_feedback_valid_o,
  output pspin_pkg::feedback_descr_t                          nic_feedback_o,
  input  logic                                                nic_feedback_ready_i,

  output logic                                                fb_done_o,
  output pspin_pkg::cluster_idx_t                             fb_cluster_o
);

  import pspin_pkg::*;

  localparam int unsigned n_clusters = `PSPIN_NUM_CLUSTERS;

  cluster_idx_t ptr_q;
  logic         hold_q;
  cluster_idx_t hold_idx_q;
  cluster_idx_t pick;
  cluster_idx_t grant;
  logic         accept;

  // First pending cluster at or after the grant pointer
  always_comb begin
    int unsigned idx;
    logic        found;
    pick  = ptr_q;
    found = 1'b0;
    for (int unsigned i = 0; i < n_clusters; i++) begin
      idx = (32'(ptr_q) + i) % n_clusters;
      if (!found && cluster_fb_valid_i[idx]) begin
        pick  = cluster_idx_t'(idx);
        found = 1'b1;
      end
    end
  end

  // Stalled grant is kept so the NIC sees a stable word
  assign grant  = hold_q ? hold_idx_q : pick;
  assign accept = nic_feedback_valid_o & nic_feedback_ready_i;

  assign nic_feedback_valid_o = cluster_fb_valid_i[grant];
  assign nic_feedback_o       = cluster_fb_i[grant];
  assign cluster_fb_ready_o   = accept ? (cluster_mask_t'(1) << grant) : '0;

  assign fb_done_o    = accept;
  assign fb_cluster_o = grant;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q      <= '0;
      hold_q     <= 1'b0;
      hold_idx_q <= '0;
    end else begin
      hold_q <= nic_feedback_valid_o & ~nic_feedback_ready_i;
      if (nic_feedback_valid_o) begin
        hold_idx_q <= grant;
      end
      if (accept) begin
        ptr_q <= cluster_idx_t'((32'(grant) + 1) % n_clusters);
      end
    end
  end

  // Pending feedback is held unchanged through a NIC stall
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (nic_feedback_valid_o && !nic_feedback_ready_i) |=>
      (nic_feedback_valid_o && $stable(nic_feedback_o)));

endmodule

// ==== src/task_scheduler.sv ====
/*
 * Task scheduler with per-cluster slot credits
 * Round-robin choice among clusters with a free handler slot
 */
`timescale 1ns/1ps
`include "pspin_settings.svh"

module task_scheduler (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  input  logic                     task_valid_i,
  input  pspin_pkg::her_descr_t    task_i,
  output logic                     task_ready_o,

  output pspin_pkg::cluster_mask_t cluster_task_valid_o,
  output pspin_pkg::her_descr_t    cluster_task_o,
  input  pspin_pkg::cluster_mask_t cluster_task_ready_i,

  input  logic                     fb_done_i,
  input  pspin_pkg::cluster_idx_t  fb_cluster_i
);

  import pspin_pkg::*;

  localparam int unsigned n_clusters = `PSPIN_NUM_CLUSTERS;
  localparam int unsigned max_credit = `PSPIN_HERS_PER_CLUSTER;
  localparam int unsigned credit_w   = $clog2(max_credit + 1);

  cluster_mask_t has_credit;
  cluster_idx_t  rr_q;
  logic          lock_q;
  cluster_idx_t  lock_idx_q;
  cluster_idx_t  pick;
  logic          pick_found;
  cluster_idx_t  sel;
  logic          offer;
  logic          accept;

  // First cluster with credit, starting at the round-robin pointer
  always_comb begin
    int unsigned idx;
    pick       = rr_q;
    pick_found = 1'b0;
    for (int unsigned i = 0; i < n_clusters; i++) begin
      idx = (32'(rr_q) + i) % n_clusters;
      if (!pick_found && has_credit[idx]) begin
        pick       = cluster_idx_t'(idx);
        pick_found = 1'b1;
      end
    end
  end

  // A pending offer stays with its cluster until taken
  assign sel    = lock_q ? lock_idx_q : pick;
  assign offer  = task_valid_i & (lock_q | pick_found);
  assign accept = offer & cluster_task_ready_i[sel];

  assign cluster_task_valid_o = offer ? (cluster_mask_t'(1) << sel) : '0;
  assign cluster_task_o       = task_i;
  assign task_ready_o         = accept;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q       <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      lock_q <= offer & ~accept;
      if (offer) begin
        lock_idx_q <= sel;
      end
      if (accept) begin
        rr_q <= cluster_idx_t'((32'(sel) + 1) % n_clusters);
      end
    end
  end

  for (genvar k = 0; k < n_clusters; k++) begin : gen_credit
    logic [credit_w-1:0] credit_q;
    logic                take;
    logic                give;

    assign take          = accept && (sel == cluster_idx_t'(k));
    assign give          = fb_done_i && (fb_cluster_i == cluster_idx_t'(k));
    assign has_credit[k] = (credit_q != '0);

    always_ff @(posedge clk_i, negedge rst_ni) begin
      if (!rst_ni) begin
        credit_q <= credit_w'(max_credit);
      end else if (take && !give) begin
        credit_q <= credit_q - 1'b1;
      end else if (give && !take) begin
        credit_q <= credit_q + 1'b1;
      end
    end

    // Issue only into a free slot
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      take |-> (credit_q != '0));

    // Feedback only for a task the cluster actually holds
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      (give && !take) |-> (credit_q < credit_w'(max_credit)));
  end

  // A refused offer stays on the same cluster with the same word
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (offer && !accept) |=>
      (cluster_task_valid_o == $past(cluster_task_valid_o)) && $stable(cluster_task_o));

endmodule

// ==== src/her_queue.sv ====
/*
 * HER queue between the NIC packet generator and the task scheduler
 * Circular buffer with read/write pointers and an entry count
 */
`timescale 1ns/1ps
`include "pspin_settings.svh"

module her_queue (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  input  logic                  her_valid_i,
  input  pspin_pkg::her_descr_t her_i,
  output logic                  her_ready_o,

  output logic                  task_valid_o,
  output pspin_pkg::her_descr_t task_o,
  input  logic                  task_ready_i
);

  import pspin_pkg::*;

  localparam int unsigned depth = `PSPIN_HER_QUEUE_DEPTH;
  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int unsigned cnt_w = $clog2(depth + 1);

  her_descr_t       mem_q [depth];
  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [cnt_w-1:0] count_q;
  logic             push;
  logic             pop;

  assign her_ready_o  = (count_q != cnt_w'(depth));
  assign task_valid_o = (count_q != '0);
  assign task_o       = mem_q[rd_ptr_q];

  assign push = her_valid_i & her_ready_o;
  assign pop  = task_valid_o & task_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= her_i;
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_w'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leaves the count unchanged
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // No write past full and no read past empty
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    count_q <= cnt_w'(depth));

  // Write pointer leads the read pointer by the entry count
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_ptr_q == ptr_w'((32'(rd_ptr_q) + 32'(count_q)) % depth));

endmodule

// ==== src/pspin_pkg.sv ====
/*
 * Descriptor words and cluster index types of the dispatch path
 */
`include "pspin_settings.svh"

package pspin_pkg;

  // Handler execution request, as issued to a cluster
  typedef logic [`PSPIN_HER_W-1:0] her_descr_t;

  // Completion feedback returned to the NIC
  typedef logic [`PSPIN_FB_W-1:0] feedback_descr_t;

  typedef logic [`PSPIN_NUM_CLUSTERS-1:0] cluster_mask_t;
  typedef logic [$clog2(`PSPIN_NUM_CLUSTERS)-1:0] cluster_idx_t;

endpackage

// ==== src/pspin_settings.svh ====
/*
 * Sizes and widths of the handler dispatch path
 */
`ifndef PSPIN_SETTINGS_SVH
`define PSPIN_SETTINGS_SVH

// Processing clusters and their task slots
`define PSPIN_NUM_CLUSTERS 4
`define PSPIN_HERS_PER_CLUSTER 2

// HER queue entries
`define PSPIN_HER_QUEUE_DEPTH 4

// Descriptor widths
`define PSPIN_HER_W 32
`define PSPIN_FB_W 32

`endif
